// File: build.f
+incdir+include
src/pad_ctrl_pkg.sv
src/reg_bus_if.sv
src/reg_bus_arbiter.sv
src/pad_regfile.sv
src/pad_mux.sv
src/pad_ctrl_top.sv
testbench/pad_ctrl_assertions.sv
testbench/pad_ctrl_checker.sv
testbench/pad_ctrl_tb.sv

// File: include/pad_ctrl_config.svh
////////////////////////////////////////////////////////////////////////////
// Pad controller configuration: pad count, register map and hardware ID
////////////////////////////////////////////////////////////////////////////

`ifndef PAD_CTRL_CONFIG_SVH
`define PAD_CTRL_CONFIG_SVH

// Number of bonded pads handled by the controller
`define PAD_COUNT 22

// Byte offsets on the register bus
`define REG_OE_OFS  16'h0000
`define REG_FN_OFS  16'h0004
`define REG_OUT_OFS 16'h0008
`define REG_IN_OFS  16'h000C
`define REG_ID_OFS  16'h0010

// Chip ID in the upper half, system info in the lower half
`define HW_ID 32'hA7D2_0103

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pad_ctrl_tb \
    -f build.f --Mdir obj_dir -o pad_ctrl_sim
./obj_dir/pad_ctrl_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: src/pad_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pad controller types shared by the bus, arbiter and register file
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package pad_ctrl_pkg;

    // One register bus request, held stable by the master until ack
    typedef struct packed {
        logic        we;
        logic [15:0] adr;
        logic [3:0]  sel;
        logic [31:0] wdata;
    } bus_req_t;

    // Owning master of the shared bus
    typedef logic master_id_t;

    localparam master_id_t MASTER_CPU = 1'b0;
    localparam master_id_t MASTER_DBG = 1'b1;

    // Register slot decoded from the bus address
    typedef enum logic [2:0] {
        REG_OE,
        REG_FN,
        REG_OUT,
        REG_IN,
        REG_ID,
        REG_NONE
    } reg_idx_e;

endpackage

`default_nettype wire

// File: src/pad_ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// Pad control subsystem: bus arbiter, register file and pad multiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "pad_ctrl_config.svh"

module pad_ctrl_top
    import pad_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Processor port
    input  logic                  cpu_cyc_i,
    input  logic                  cpu_stb_i,
    input  logic                  cpu_we_i,
    input  logic [15:0]           cpu_adr_i,
    input  logic [3:0]            cpu_sel_i,
    input  logic [31:0]           cpu_dat_i,
    output logic [31:0]           cpu_dat_o,
    output logic                  cpu_ack_o,

    // Debug port
    input  logic                  dbg_cyc_i,
    input  logic                  dbg_stb_i,
    input  logic                  dbg_we_i,
    input  logic [15:0]           dbg_adr_i,
    input  logic [3:0]            dbg_sel_i,
    input  logic [31:0]           dbg_dat_i,
    output logic [31:0]           dbg_dat_o,
    output logic                  dbg_ack_o,

    // Special functions and pads
    input  logic [`PAD_COUNT-1:0] sf_oe_i,
    input  logic [`PAD_COUNT-1:0] sf_out_i,
    output logic [`PAD_COUNT-1:0] sf_in_o,
    input  logic [`PAD_COUNT-1:0] pad_in_i,
    output logic [`PAD_COUNT-1:0] pad_oe_o,
    output logic [`PAD_COUNT-1:0] pad_out_o
);

    bus_req_t              cpu_req;
    bus_req_t              dbg_req;
    logic [`PAD_COUNT-1:0] gpio_oe;
    logic [`PAD_COUNT-1:0] gpio_fn;
    logic [`PAD_COUNT-1:0] gpio_out;
    logic [`PAD_COUNT-1:0] pad_in_sync;

    reg_bus_if reg_bus ();

    assign cpu_req = '{we: cpu_we_i, adr: cpu_adr_i, sel: cpu_sel_i, wdata: cpu_dat_i};
    assign dbg_req = '{we: dbg_we_i, adr: dbg_adr_i, sel: dbg_sel_i, wdata: dbg_dat_i};

    reg_bus_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .m0_cyc_i   (cpu_cyc_i),
        .m0_stb_i   (cpu_stb_i),
        .m0_req_i   (cpu_req),
        .m0_rdata_o (cpu_dat_o),
        .m0_ack_o   (cpu_ack_o),
        .m1_cyc_i   (dbg_cyc_i),
        .m1_stb_i   (dbg_stb_i),
        .m1_req_i   (dbg_req),
        .m1_rdata_o (dbg_dat_o),
        .m1_ack_o   (dbg_ack_o),
        .bus        (reg_bus.master)
    );

    pad_regfile u_regfile (
        .clk           (clk),
        .rst           (rst),
        .bus           (reg_bus.slave),
        .pad_in_sync_i (pad_in_sync),
        .gpio_oe_o     (gpio_oe),
        .gpio_fn_o     (gpio_fn),
        .gpio_out_o    (gpio_out)
    );

    pad_mux u_pad_mux (
        .clk           (clk),
        .rst           (rst),
        .gpio_oe_i     (gpio_oe),
        .gpio_fn_i     (gpio_fn),
        .gpio_out_i    (gpio_out),
        .sf_oe_i       (sf_oe_i),
        .sf_out_i      (sf_out_i),
        .pad_in_i      (pad_in_i),
        .pad_oe_o      (pad_oe_o),
        .pad_out_o     (pad_out_o),
        .pad_in_sync_o (pad_in_sync),
        .sf_in_o       (sf_in_o)
    );

endmodule

`default_nettype wire

// File: src/pad_mux.sv
////////////////////////////////////////////////////////////////////////////
// Pad multiplexer between GPIO and special function, input synchronizer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "pad_ctrl_config.svh"

module pad_mux (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`PAD_COUNT-1:0] gpio_oe_i,
    input  logic [`PAD_COUNT-1:0] gpio_fn_i,
    input  logic [`PAD_COUNT-1:0] gpio_out_i,
    input  logic [`PAD_COUNT-1:0] sf_oe_i,
    input  logic [`PAD_COUNT-1:0] sf_out_i,
    input  logic [`PAD_COUNT-1:0] pad_in_i,
    output logic [`PAD_COUNT-1:0] pad_oe_o,
    output logic [`PAD_COUNT-1:0] pad_out_o,
    output logic [`PAD_COUNT-1:0] pad_in_sync_o,
    output logic [`PAD_COUNT-1:0] sf_in_o
);

    logic [`PAD_COUNT-1:0] meta_q;
    logic [`PAD_COUNT-1:0] sync_q;

    // FN bit set selects the special function for that pad
    assign pad_oe_o  = (gpio_fn_i & sf_oe_i) | (~gpio_fn_i & gpio_oe_i);
    assign pad_out_o = (gpio_fn_i & sf_out_i) | (~gpio_fn_i & gpio_out_i);

    // Two flops, pad_in is asynchronous to clk
    always_ff @(posedge clk) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= pad_in_i;
            sync_q <= meta_q;
        end
    end

    assign pad_in_sync_o = sync_q;
    assign sf_in_o       = sync_q;

endmodule

`default_nettype wire

// File: src/pad_regfile.sv
////////////////////////////////////////////////////////////////////////////
// Pad register file: direction, function and output data, plus readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "pad_ctrl_config.svh"

module pad_regfile
    import pad_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    reg_bus_if.slave              bus,
    input  logic [`PAD_COUNT-1:0] pad_in_sync_i,
    output logic [`PAD_COUNT-1:0] gpio_oe_o,
    output logic [`PAD_COUNT-1:0] gpio_fn_o,
    output logic [`PAD_COUNT-1:0] gpio_out_o
);

    localparam int unsigned PAD_FILL = 32 - `PAD_COUNT;

    reg_idx_e              idx;
    logic                  access;
    logic                  done_q;
    logic [`PAD_COUNT-1:0] wr_mask;
    logic [`PAD_COUNT-1:0] wr_data;
    logic [31:0]           rd_word;

    always_comb begin
        case (bus.req.adr)
            `REG_OE_OFS:  idx = REG_OE;
            `REG_FN_OFS:  idx = REG_FN;
            `REG_OUT_OFS: idx = REG_OUT;
            `REG_IN_OFS:  idx = REG_IN;
            `REG_ID_OFS:  idx = REG_ID;
            default:      idx = REG_NONE;
        endcase
    end

    // First cycle of a cycle only, no second ack while cyc stays high
    assign access = bus.cyc && bus.stb && !bus.ack && !done_q;

    // Byte lanes, the top lane falls away above the last pad
    always_comb begin
        for (int i = 0; i < `PAD_COUNT; i++) begin
            wr_mask[i] = bus.req.sel[i / 8];
        end
    end

    assign wr_data = bus.req.wdata[`PAD_COUNT-1:0];

    always_comb begin
        case (idx)
            REG_OE:  rd_word = {{PAD_FILL{1'b0}}, gpio_oe_o};
            REG_FN:  rd_word = {{PAD_FILL{1'b0}}, gpio_fn_o};
            REG_OUT: rd_word = {{PAD_FILL{1'b0}}, gpio_out_o};
            REG_IN:  rd_word = {{PAD_FILL{1'b0}}, pad_in_sync_i};
            REG_ID:  rd_word = `HW_ID;
            default: rd_word = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack   <= 1'b0;
            bus.rdata <= 32'h0;
            done_q    <= 1'b0;
        end else begin
            bus.ack   <= access;
            bus.rdata <= (access && !bus.req.we) ? rd_word : 32'h0;
            if (!bus.cyc) begin
                done_q <= 1'b0;
            end else if (bus.ack) begin
                done_q <= 1'b1;
            end
        end
    end

    // Writes land on the same edge that raises ack; IN and ID are read only
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_oe_o  <= '0;
            gpio_fn_o  <= '0;
            gpio_out_o <= '0;
        end else if (access && bus.req.we) begin
            case (idx)
                REG_OE:  gpio_oe_o  <= (gpio_oe_o & ~wr_mask) | (wr_data & wr_mask);
                REG_FN:  gpio_fn_o  <= (gpio_fn_o & ~wr_mask) | (wr_data & wr_mask);
                REG_OUT: gpio_out_o <= (gpio_out_o & ~wr_mask) | (wr_data & wr_mask);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/reg_bus_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter giving one of two masters the shared register bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_bus_arbiter
    import pad_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Processor side
    input  logic         m0_cyc_i,
    input  logic         m0_stb_i,
    input  bus_req_t     m0_req_i,
    output logic [31:0]  m0_rdata_o,
    output logic         m0_ack_o,

    // Debug side
    input  logic         m1_cyc_i,
    input  logic         m1_stb_i,
    input  bus_req_t     m1_req_i,
    output logic [31:0]  m1_rdata_o,
    output logic         m1_ack_o,

    reg_bus_if.master    bus
);

    logic       busy_q;
    // Keeps its value after release and then acts as the last granted master
    master_id_t owner_q;
    master_id_t pick;
    logic       sel_m0;
    logic       sel_m1;

    // On a tie the master that was not granted last wins
    always_comb begin
        if (m0_cyc_i && m1_cyc_i) begin
            pick = ~owner_q;
        end else if (m1_cyc_i) begin
            pick = MASTER_DBG;
        end else begin
            pick = MASTER_CPU;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= MASTER_DBG;
        end else if (!busy_q) begin
            if (m0_cyc_i || m1_cyc_i) begin
                busy_q  <= 1'b1;
                owner_q <= pick;
            end
        end else if (bus.ack) begin
            // Release once the ack cycle has passed
            busy_q <= 1'b0;
        end
    end

    assign sel_m0 = busy_q && (owner_q == MASTER_CPU);
    assign sel_m1 = busy_q && (owner_q == MASTER_DBG);

    // Owner request goes straight through to the slave
    assign bus.cyc = (sel_m0 && m0_cyc_i) || (sel_m1 && m1_cyc_i);
    assign bus.stb = (sel_m0 && m0_stb_i) || (sel_m1 && m1_stb_i);
    assign bus.req = sel_m1 ? m1_req_i : m0_req_i;

    // Response steered to the owner only
    assign m0_ack_o   = sel_m0 && bus.ack;
    assign m1_ack_o   = sel_m1 && bus.ack;
    assign m0_rdata_o = sel_m0 ? bus.rdata : 32'h0;
    assign m1_rdata_o = sel_m1 ? bus.rdata : 32'h0;

endmodule

`default_nettype wire

// File: src/reg_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone-style register bus, classic cyc/stb/ack single accesses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if
    import pad_ctrl_pkg::*;
();

    logic        cyc;
    logic        stb;
    bus_req_t    req;
    // Read data is only non-zero in the ack cycle
    logic [31:0] rdata;
    logic        ack;

    modport master (
        output cyc,
        output stb,
        output req,
        input  rdata,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  req,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// File: testbench/pad_ctrl_assertions.sv
////////////////////////////////////////////////////////////////////////////
// Handshake assertions on the pad controller ports, bound to the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_assertions (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_ack_i,
    input  logic        dbg_ack_i,
    input  logic [31:0] cpu_dat_i,
    input  logic [31:0] dbg_dat_i
);

    int fail_count;

    initial fail_count = 0;

    cpu_ack_single: assert property (@(posedge clk) disable iff (rst)
        cpu_ack_i |=> !cpu_ack_i)
        else begin
            fail_count++;
            $error("cpu ack stayed high for more than one cycle");
        end

    dbg_ack_single: assert property (@(posedge clk) disable iff (rst)
        dbg_ack_i |=> !dbg_ack_i)
        else begin
            fail_count++;
            $error("dbg ack stayed high for more than one cycle");
        end

    acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cpu_ack_i && dbg_ack_i))
        else begin
            fail_count++;
            $error("cpu and dbg ack high in the same cycle");
        end

    cpu_rdata_idle: assert property (@(posedge clk) disable iff (rst)
        !cpu_ack_i |-> cpu_dat_i == 32'h0)
        else begin
            fail_count++;
            $error("cpu read data not zero outside ack");
        end

    dbg_rdata_idle: assert property (@(posedge clk) disable iff (rst)
        !dbg_ack_i |-> dbg_dat_i == 32'h0)
        else begin
            fail_count++;
            $error("dbg read data not zero outside ack");
        end

    // Second reset cycle on, flops are cleared by then
    acks_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !cpu_ack_i && !dbg_ack_i)
        else begin
            fail_count++;
            $error("ack high while reset is asserted");
        end

endmodule

bind pad_ctrl_top pad_ctrl_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .cpu_ack_i (cpu_ack_o),
    .dbg_ack_i (dbg_ack_o),
    .cpu_dat_i (cpu_dat_o),
    .dbg_dat_i (dbg_dat_o)
);

`default_nettype wire

// File: testbench/pad_ctrl_checker.sv
////////////////////////////////////////////////////////////////////////////
// Pad controller checker: register model, readback and pad output compare
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "pad_ctrl_config.svh"

module pad_ctrl_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [2:0]            test_idx_i,
    input  logic                  cpu_cyc_i,
    input  logic                  cpu_we_i,
    input  logic [15:0]           cpu_adr_i,
    input  logic [3:0]            cpu_sel_i,
    input  logic [31:0]           cpu_wdat_i,
    input  logic [31:0]           cpu_rdat_i,
    input  logic                  cpu_ack_i,
    input  logic                  dbg_cyc_i,
    input  logic                  dbg_we_i,
    input  logic [15:0]           dbg_adr_i,
    input  logic [3:0]            dbg_sel_i,
    input  logic [31:0]           dbg_wdat_i,
    input  logic [31:0]           dbg_rdat_i,
    input  logic                  dbg_ack_i,
    input  logic [`PAD_COUNT-1:0] sf_oe_i,
    input  logic [`PAD_COUNT-1:0] sf_out_i,
    input  logic [`PAD_COUNT-1:0] sf_in_i,
    input  logic [`PAD_COUNT-1:0] pad_in_i,
    input  logic [`PAD_COUNT-1:0] pad_oe_i,
    input  logic [`PAD_COUNT-1:0] pad_out_i,
    output int                    check_count_o,
    output int                    error_count_o,
    output int                    cpu_acks_o,
    output int                    dbg_acks_o
);

    localparam logic [31:0] PAD_MASK = (32'h1 << `PAD_COUNT) - 32'h1;

    logic [31:0]           model_oe;
    logic [31:0]           model_fn;
    logic [31:0]           model_out;
    logic [1:0]            acked;
    logic [2:0]            last_idx;
    logic [`PAD_COUNT-1:0] last_pad_in;
    int                    stable_cnt;
    int                    test_checks;
    int                    test_errors;

    initial begin
        check_count_o = 0;
        error_count_o = 0;
        cpu_acks_o    = 0;
        dbg_acks_o    = 0;
        test_checks   = 0;
        test_errors   = 0;
        last_idx      = 3'd0;
    end

    function automatic string test_name(input logic [2:0] idx);
        case (idx)
            3'd0:    return "reset_state";
            3'd1:    return "byte_write";
            3'd2:    return "arbitration";
            3'd3:    return "pad_mux";
            3'd4:    return "input_path";
            default: return "done";
        endcase
    endfunction

    // Each selected byte lane lands, bits above the last pad stay zero
    function automatic logic [31:0] apply_write(input logic [31:0] cur,
                                                input logic [3:0]  sel,
                                                input logic [31:0] wdata);
        logic [31:0] next;
        next = cur;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                next[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return next & PAD_MASK;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        test_checks++;
        check_count_o++;
        if (exp !== act) begin
            $display("MISMATCH test=%s %s expected=%h actual=%h",
                     test_name(test_idx_i), what, exp, act);
            test_errors++;
            error_count_o++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR test=%s %s", test_name(test_idx_i), msg);
        test_errors++;
        error_count_o++;
    endtask

    task automatic handle_ack(input string port, input logic we, input logic [15:0] adr,
                              input logic [3:0] sel, input logic [31:0] wdata,
                              input logic [31:0] rdata);
        string what;
        what = $sformatf("%s read %h", port, adr);
        if (we) begin
            case (adr)
                `REG_OE_OFS:  model_oe  = apply_write(model_oe, sel, wdata);
                `REG_FN_OFS:  model_fn  = apply_write(model_fn, sel, wdata);
                `REG_OUT_OFS: model_out = apply_write(model_out, sel, wdata);
                default:      ;
            endcase
        end else begin
            case (adr)
                `REG_OE_OFS:  check_value(what, model_oe, rdata);
                `REG_FN_OFS:  check_value(what, model_fn, rdata);
                `REG_OUT_OFS: check_value(what, model_out, rdata);
                `REG_ID_OFS:  check_value(what, `HW_ID, rdata);
                `REG_IN_OFS: begin
                    // Only once the synchronizer has seen a steady input
                    if (stable_cnt >= 4) begin
                        check_value(what, 32'(pad_in_i), rdata);
                    end
                end
                default:      check_value(what, 32'h0, rdata);
            endcase
        end
    endtask

    task automatic watch_port(input bit is_dbg, input logic cyc, input logic ack,
                              input logic we, input logic [15:0] adr,
                              input logic [3:0] sel, input logic [31:0] wdata,
                              input logic [31:0] rdata);
        string port;
        port = is_dbg ? "dbg" : "cpu";
        if (ack && !cyc) begin
            report_failure($sformatf("ack on idle %s port", port));
        end
        if (ack && acked[is_dbg]) begin
            report_failure($sformatf("second ack on %s port for one access", port));
        end
        if (ack) begin
            acked[is_dbg] = 1'b1;
            if (is_dbg) begin
                dbg_acks_o++;
            end else begin
                cpu_acks_o++;
            end
            handle_ack(port, we, adr, sel, wdata, rdata);
        end
        if (!cyc) begin
            acked[is_dbg] = 1'b0;
        end
    endtask

    task automatic check_pads();
        logic [`PAD_COUNT-1:0] exp_oe;
        logic [`PAD_COUNT-1:0] exp_out;
        for (int i = 0; i < `PAD_COUNT; i++) begin
            exp_oe[i]  = model_fn[i] ? sf_oe_i[i] : model_oe[i];
            exp_out[i] = model_fn[i] ? sf_out_i[i] : model_out[i];
        end
        check_value("pad_oe", 32'(exp_oe), 32'(pad_oe_i));
        check_value("pad_out", 32'(exp_out), 32'(pad_out_i));
        if (stable_cnt >= 3) begin
            check_value("sf_in", 32'(pad_in_i), 32'(sf_in_i));
        end
    endtask

    // Values seen here are the ones of the cycle that just ended
    always @(posedge clk) begin
        if (test_idx_i != last_idx) begin
            $display("test %s finished: %0d checks, %0d errors",
                     test_name(last_idx), test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
            last_idx    = test_idx_i;
        end
        if (rst) begin
            model_oe    = 32'h0;
            model_fn    = 32'h0;
            model_out   = 32'h0;
            acked       = 2'b00;
            stable_cnt  = 0;
            last_pad_in = pad_in_i;
        end else begin
            if (pad_in_i == last_pad_in) begin
                if (stable_cnt < 8) begin
                    stable_cnt++;
                end
            end else begin
                stable_cnt = 0;
            end
            last_pad_in = pad_in_i;
            // Write acks first, the registers already hold the new value
            watch_port(1'b0, cpu_cyc_i, cpu_ack_i, cpu_we_i, cpu_adr_i, cpu_sel_i,
                       cpu_wdat_i, cpu_rdat_i);
            watch_port(1'b1, dbg_cyc_i, dbg_ack_i, dbg_we_i, dbg_adr_i, dbg_sel_i,
                       dbg_wdat_i, dbg_rdat_i);
            check_pads();
        end
    end

endmodule

`default_nettype wire

// File: testbench/pad_ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// Pad controller testbench: random traffic on both bus ports, final report
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "pad_ctrl_config.svh"

module pad_ctrl_tb
    import pad_ctrl_pkg::*;
();

    localparam int          CLK_PERIOD     = 4;
    localparam int          RESET_CYCLES   = 4;
    localparam logic [31:0] SEED           = 32'd40306;
    localparam int          WRITE_TESTS    = 24;
    localparam int          ARB_TESTS      = 24;
    localparam int          MUX_ROUNDS     = 8;
    localparam int          INPUT_ROUNDS   = 6;
    localparam int          ACCESS_TIMEOUT = 32;
    // Contention wait plus start gap plus the two cycle access
    localparam int          ACCESS_CYCLES  = 16;
    localparam int          TOTAL_ACCESSES = 5 + WRITE_TESTS + 3 + 2 * ARB_TESTS
                                             + 3 * MUX_ROUNDS + 2 * INPUT_ROUNDS;
    localparam int          WATCHDOG_NS    = (TOTAL_ACCESSES * ACCESS_CYCLES + 200)
                                             * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  cpu_cyc;
    logic                  cpu_stb;
    logic                  cpu_we;
    logic [15:0]           cpu_adr;
    logic [3:0]            cpu_sel;
    logic [31:0]           cpu_wdat;
    logic [31:0]           cpu_rdat;
    logic                  cpu_ack;
    logic                  dbg_cyc;
    logic                  dbg_stb;
    logic                  dbg_we;
    logic [15:0]           dbg_adr;
    logic [3:0]            dbg_sel;
    logic [31:0]           dbg_wdat;
    logic [31:0]           dbg_rdat;
    logic                  dbg_ack;
    logic [`PAD_COUNT-1:0] sf_oe;
    logic [`PAD_COUNT-1:0] sf_out;
    logic [`PAD_COUNT-1:0] sf_in;
    logic [`PAD_COUNT-1:0] pad_in;
    logic [`PAD_COUNT-1:0] pad_oe;
    logic [`PAD_COUNT-1:0] pad_out;
    logic [2:0]            test_idx;
    logic [31:0]           lcg_state;
    int                    tb_errors;
    int                    cpu_reqs;
    int                    dbg_reqs;
    int                    check_count;
    int                    error_count;
    int                    cpu_acks;
    int                    dbg_acks;
    bus_req_t              arb_req [2][ARB_TESTS];
    int                    arb_gap [2][ARB_TESTS];

    pad_ctrl_top pad_ctrl_top_i (
        .clk (clk), .rst (rst),
        .cpu_cyc_i (cpu_cyc), .cpu_stb_i (cpu_stb), .cpu_we_i (cpu_we),
        .cpu_adr_i (cpu_adr), .cpu_sel_i (cpu_sel), .cpu_dat_i (cpu_wdat),
        .cpu_dat_o (cpu_rdat), .cpu_ack_o (cpu_ack),
        .dbg_cyc_i (dbg_cyc), .dbg_stb_i (dbg_stb), .dbg_we_i (dbg_we),
        .dbg_adr_i (dbg_adr), .dbg_sel_i (dbg_sel), .dbg_dat_i (dbg_wdat),
        .dbg_dat_o (dbg_rdat), .dbg_ack_o (dbg_ack),
        .sf_oe_i (sf_oe), .sf_out_i (sf_out), .sf_in_o (sf_in),
        .pad_in_i (pad_in), .pad_oe_o (pad_oe), .pad_out_o (pad_out)
    );

    pad_ctrl_checker u_checker (
        .clk (clk), .rst (rst), .test_idx_i (test_idx),
        .cpu_cyc_i (cpu_cyc), .cpu_we_i (cpu_we), .cpu_adr_i (cpu_adr),
        .cpu_sel_i (cpu_sel), .cpu_wdat_i (cpu_wdat), .cpu_rdat_i (cpu_rdat),
        .cpu_ack_i (cpu_ack),
        .dbg_cyc_i (dbg_cyc), .dbg_we_i (dbg_we), .dbg_adr_i (dbg_adr),
        .dbg_sel_i (dbg_sel), .dbg_wdat_i (dbg_wdat), .dbg_rdat_i (dbg_rdat),
        .dbg_ack_i (dbg_ack),
        .sf_oe_i (sf_oe), .sf_out_i (sf_out), .sf_in_i (sf_in), .pad_in_i (pad_in),
        .pad_oe_i (pad_oe), .pad_out_i (pad_out),
        .check_count_o (check_count), .error_count_o (error_count),
        .cpu_acks_o (cpu_acks), .dbg_acks_o (dbg_acks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bus_req_t make_req(input logic we, input logic [15:0] adr,
                                          input logic [31:0] wdata);
        bus_req_t r;
        r.we    = we;
        r.adr   = adr;
        r.sel   = 4'hF;
        r.wdata = wdata;
        return r;
    endfunction

    // Mostly pad registers with some read-only and unmapped addresses
    function automatic bus_req_t random_req();
        bus_req_t    r;
        logic [31:0] rnd;
        rnd   = lcg_next();
        r.we  = rnd[31];
        r.sel = rnd[19:16];
        case (rnd[30:28])
            3'd0, 3'd6: r.adr = `REG_OE_OFS;
            3'd1:       r.adr = `REG_FN_OFS;
            3'd2, 3'd7: r.adr = `REG_OUT_OFS;
            3'd3:       r.adr = `REG_IN_OFS;
            3'd4:       r.adr = `REG_ID_OFS;
            default:    r.adr = rnd[15:0];
        endcase
        r.wdata = lcg_next();
        return r;
    endfunction

    task automatic drive_port(input bit is_dbg, input logic cyc, input bus_req_t req);
        if (is_dbg) begin
            dbg_cyc  = cyc;
            dbg_stb  = cyc;
            dbg_we   = req.we;
            dbg_adr  = req.adr;
            dbg_sel  = req.sel;
            dbg_wdat = req.wdata;
        end else begin
            cpu_cyc  = cyc;
            cpu_stb  = cyc;
            cpu_we   = req.we;
            cpu_adr  = req.adr;
            cpu_sel  = req.sel;
            cpu_wdat = req.wdata;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge that drops cyc
    task automatic bus_access(input bit is_dbg, input bus_req_t req, input int gap);
        int waited;
        bit got_ack;
        repeat (gap + 1) @(negedge clk);
        drive_port(is_dbg, 1'b1, req);
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < ACCESS_TIMEOUT) begin
            @(negedge clk);
            got_ack = is_dbg ? dbg_ack : cpu_ack;
            waited++;
        end
        // Request stays up until the ack cycle has ended on the rising edge
        if (got_ack) begin
            @(negedge clk);
        end
        drive_port(is_dbg, 1'b0, '0);
        if (is_dbg) begin
            dbg_reqs++;
        end else begin
            cpu_reqs++;
        end
        if (!got_ack) begin
            $display("ERROR no ack on %s port within %0d cycles for address %h",
                     is_dbg ? "dbg" : "cpu", ACCESS_TIMEOUT, req.adr);
            tb_errors++;
        end
    endtask

    task automatic run_master(input bit is_dbg);
        for (int i = 0; i < ARB_TESTS; i++) begin
            bus_access(is_dbg, arb_req[is_dbg][i], arb_gap[is_dbg][i]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired after %0d ns, the run did not finish",
                 WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          fails;
        clk       = 1'b0;
        rst       = 1'b1;
        lcg_state = SEED;
        test_idx  = 3'd0;
        tb_errors = 0;
        cpu_reqs  = 0;
        dbg_reqs  = 0;
        sf_oe     = '0;
        sf_out    = '0;
        pad_in    = '0;
        drive_port(1'b0, 1'b0, '0);
        drive_port(1'b1, 1'b0, '0);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        bus_access(1'b0, make_req(1'b0, `REG_OE_OFS, 32'h0), 0);
        bus_access(1'b1, make_req(1'b0, `REG_FN_OFS, 32'h0), 0);
        bus_access(1'b0, make_req(1'b0, `REG_OUT_OFS, 32'h0), 0);
        bus_access(1'b1, make_req(1'b0, `REG_IN_OFS, 32'h0), 0);
        bus_access(1'b0, make_req(1'b0, `REG_ID_OFS, 32'h0), 0);

        test_idx = 3'd1;
        for (int i = 0; i < WRITE_TESTS; i++) begin
            bus_access(i[0], random_req(), 0);
        end
        bus_access(1'b0, make_req(1'b0, `REG_OE_OFS, 32'h0), 0);
        bus_access(1'b1, make_req(1'b0, `REG_FN_OFS, 32'h0), 0);
        bus_access(1'b0, make_req(1'b0, `REG_OUT_OFS, 32'h0), 0);

        test_idx = 3'd2;
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < ARB_TESTS; i++) begin
                arb_req[m][i] = random_req();
                rnd           = lcg_next();
                arb_gap[m][i] = int'(rnd[1:0]);
            end
        end
        fork
            run_master(1'b0);
            run_master(1'b1);
        join

        test_idx = 3'd3;
        for (int r = 0; r < MUX_ROUNDS; r++) begin
            @(negedge clk);
            rnd    = lcg_next();
            sf_oe  = rnd[`PAD_COUNT-1:0];
            rnd    = lcg_next();
            sf_out = rnd[`PAD_COUNT-1:0];
            bus_access(1'b0, make_req(1'b1, `REG_FN_OFS, lcg_next()), 0);
            bus_access(1'b1, make_req(1'b1, `REG_OE_OFS, lcg_next()), 0);
            bus_access(1'b0, make_req(1'b1, `REG_OUT_OFS, lcg_next()), 0);
            repeat (2) @(negedge clk);
        end

        test_idx = 3'd4;
        for (int r = 0; r < INPUT_ROUNDS; r++) begin
            rnd    = lcg_next();
            pad_in = rnd[`PAD_COUNT-1:0];
            repeat (4) @(negedge clk);
            bus_access(1'b0, make_req(1'b0, `REG_IN_OFS, 32'h0), 0);
            bus_access(1'b1, make_req(1'b0, `REG_IN_OFS, 32'h0), 0);
        end

        test_idx = 3'd5;
        repeat (2) @(negedge clk);
        if (cpu_acks != cpu_reqs) begin
            $display("ERROR cpu port saw %0d acks for %0d requests", cpu_acks, cpu_reqs);
            tb_errors++;
        end
        if (dbg_acks != dbg_reqs) begin
            $display("ERROR dbg port saw %0d acks for %0d requests", dbg_acks, dbg_reqs);
            tb_errors++;
        end
        fails = tb_errors + error_count + pad_ctrl_top_i.u_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, tb_errors + error_count,
                 pad_ctrl_top_i.u_assertions.fail_count);
        if (fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
